/* all.f */
hw/fm_pkg.sv
hw/fm_slot_if.sv
hw/fm_write_decoder.sv
hw/fm_slot_regs.sv
hw/fm_keyon.sv
hw/fm_algorithm_router.sv
hw/fm_regs_top.sv
verif/fm_regs_tb.sv

/* hw/fm_algorithm_router.sv */
/*
 * Algorithm router
 * From the channel algorithm and the slot's operator role, gives the
 * operators that modulate this one and whether it is a carrier
 */
`timescale 1ns/100ps
`default_nettype none

module fm_algorithm_router (
	input wire logic clk,
	fm_slot_if.dst slot_in,
	output logic [3:0] mod_mask,
	output logic carrier
);
	import fm_pkg::*;

	op_role_e role;
	logic [2:0] con;
	logic [3:0] src_m2; // Bit order M1, M2, C1, C2 from bit 0
	logic [3:0] src_c1;
	logic [3:0] src_c2;
	logic [3:0] mask_d;
	logic carrier_d;

	assign role = op_role_e'(slot_in.slot[4:3]);
	assign con = slot_in.ch.con;

	always_comb begin
		src_m2 = 4'b0000;
		src_c1 = 4'b0000;
		src_c2 = 4'b0000;
		case (con)
			3'd0: begin src_c1 = 4'b0001; src_m2 = 4'b0100; src_c2 = 4'b0010; end
			3'd1: begin src_m2 = 4'b0101; src_c2 = 4'b0010; end
			3'd2: begin src_m2 = 4'b0100; src_c2 = 4'b0011; end
			3'd3: begin src_c1 = 4'b0001; src_c2 = 4'b0110; end
			3'd4: begin src_c1 = 4'b0001; src_c2 = 4'b0010; end
			3'd5: begin src_c1 = 4'b0001; src_m2 = 4'b0001; src_c2 = 4'b0001; end
			3'd6: src_c1 = 4'b0001;
			default: ; // All carriers
		endcase
		case (role)
			ROLE_M2: mask_d = src_m2;
			ROLE_C1: mask_d = src_c1;
			ROLE_C2: mask_d = src_c2;
			default: mask_d = 4'b0000; // M1 takes only its own feedback
		endcase
		case (con)
			3'd4: carrier_d = role == ROLE_C1 || role == ROLE_C2;
			3'd5, 3'd6: carrier_d = role != ROLE_M1;
			3'd7: carrier_d = 1'b1;
			default: carrier_d = role == ROLE_C2;
		endcase
	end

	always_ff @(posedge clk) begin
		mod_mask <= mask_d;
		carrier <= carrier_d;
	end

endmodule

`default_nettype wire

/* hw/fm_keyon.sv */
/*
 * Key-on store
 * One key-on bit per slot, replaced four at a time by key-on writes,
 * read out for the visited slot together with the delayed stream
 */
`timescale 1ns/100ps
`default_nettype none

module fm_keyon #(
	parameter int NUM_SLOTS = fm_pkg::NUM_SLOTS
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic upd_pending,
	input wire fm_pkg::reg_group_e upd_group,
	input wire fm_pkg::reg_byte_u upd_data,
	fm_slot_if.dst slot_in,
	output logic keyon,
	output logic [4:0] out_slot,
	output logic out_zero,
	output fm_pkg::op_params_t out_op,
	output fm_pkg::ch_params_t out_ch
);
	import fm_pkg::*;

	logic [NUM_SLOTS-1:0] kon_bits;
	logic [NUM_SLOTS-1:0] kon_next;
	logic kon_hit;

	// First visit to the addressed channel, same cycle the update is applied
	assign kon_hit = upd_pending && upd_group == GRP_KEYON &&
		slot_in.slot[2:0] == upd_data.keyon.ch;

	always_comb begin
		kon_next = kon_bits;
		if (kon_hit) begin
			for (int op = 0; op < 4; op++) begin
				kon_next[{op[1:0], upd_data.keyon.ch}] = upd_data.keyon.op_mask[op]; // M1 is bit 0
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			kon_bits <= '0;
			keyon <= 1'b0;
		end else begin
			kon_bits <= kon_next;
			keyon <= kon_next[slot_in.slot]; // New value shows on the applying visit
		end
	end

	always_ff @(posedge clk) begin
		out_slot <= slot_in.slot;
		out_zero <= slot_in.zero;
		out_op <= slot_in.op;
		out_ch <= slot_in.ch;
	end

endmodule

`default_nettype wire

/* hw/fm_pkg.sv */
/*
 * FM register file package
 * Register map, slot and channel counts, parameter records and the
 * data byte views shared by the decoder, slot memories and key-on store
 */
`default_nettype none

package fm_pkg;

	localparam int NUM_SLOTS = 32;
	localparam int NUM_CH = 8;

	// Channel groups, channel in addr[2:0]
	localparam logic [7:0] ADDR_KEYON = 8'h08;
	localparam logic [7:0] ADDR_RL_FB_CON = 8'h20;
	localparam logic [7:0] ADDR_KC = 8'h28;
	localparam logic [7:0] ADDR_KF = 8'h30;
	localparam logic [7:0] ADDR_PMS_AMS = 8'h38;
	// Operator groups, op in addr[4:3] and channel in addr[2:0]
	localparam logic [7:0] ADDR_DT1_MUL = 8'h40;
	localparam logic [7:0] ADDR_TL = 8'h60;
	localparam logic [7:0] ADDR_KS_AR = 8'h80;
	localparam logic [7:0] ADDR_AMSEN_D1R = 8'hA0;
	localparam logic [7:0] ADDR_DT2_D2R = 8'hC0;
	localparam logic [7:0] ADDR_D1L_RR = 8'hE0;

	typedef enum logic [3:0] {
		GRP_NONE,
		GRP_KEYON,
		GRP_RL_FB_CON,
		GRP_KC,
		GRP_KF,
		GRP_PMS_AMS,
		GRP_DT1_MUL,
		GRP_TL,
		GRP_KS_AR,
		GRP_AMSEN_D1R,
		GRP_DT2_D2R,
		GRP_D1L_RR
	} reg_group_e;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic amsen;
		logic [4:0] d1r;
		logic [1:0] dt2;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
	} op_params_t; // 42 bits

	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] fb;
		logic [2:0] con;
		logic [6:0] kc;
		logic [5:0] kf;
		logic [2:0] pms;
		logic [1:0] ams;
	} ch_params_t; // 26 bits

	// One data byte, laid out per register group
	typedef union packed {
		logic [7:0] raw; // TL, KC and KF use plain slices
		struct packed {logic [1:0] rl; logic [2:0] fb; logic [2:0] con;} rl_fb_con;
		struct packed {logic rsvd; logic [2:0] pms; logic [1:0] rsvd2; logic [1:0] ams;} pms_ams;
		struct packed {logic rsvd; logic [2:0] dt1; logic [3:0] mul;} dt1_mul;
		struct packed {logic [1:0] ks; logic rsvd; logic [4:0] ar;} ks_ar;
		struct packed {logic amsen; logic [1:0] rsvd; logic [4:0] d1r;} amsen_d1r;
		struct packed {logic [1:0] dt2; logic rsvd; logic [4:0] d2r;} dt2_d2r;
		struct packed {logic [3:0] d1l; logic [3:0] rr;} d1l_rr;
		struct packed {logic rsvd; logic [3:0] op_mask; logic [2:0] ch;} keyon;
	} reg_byte_u;

	// Operator role is slot[4:3]
	typedef enum logic [1:0] {
		ROLE_M1 = 2'd0,
		ROLE_M2 = 2'd1,
		ROLE_C1 = 2'd2,
		ROLE_C2 = 2'd3
	} op_role_e;

endpackage

`default_nettype wire

/* hw/fm_regs_top.sv */
/*
 * FM register file and slot sequencer
 * Host write port in, per-slot operator and channel parameters,
 * key-on and modulation routing out, aligned with out_slot
 */
`timescale 1ns/100ps
`default_nettype none

module fm_regs_top #(
	parameter int NUM_SLOTS = fm_pkg::NUM_SLOTS,
	parameter int NUM_CH = fm_pkg::NUM_CH
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic wr,
	input wire logic [7:0] addr,
	input wire logic [7:0] din,
	output logic busy,
	output logic [4:0] out_slot,
	output logic out_zero,
	output logic [2:0] dt1,
	output logic [3:0] mul,
	output logic [6:0] tl,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic amsen,
	output logic [4:0] d1r,
	output logic [1:0] dt2,
	output logic [4:0] d2r,
	output logic [3:0] d1l,
	output logic [3:0] rr,
	output logic [1:0] rl,
	output logic [2:0] fb,
	output logic [2:0] con,
	output logic [6:0] kc,
	output logic [5:0] kf,
	output logic [2:0] pms,
	output logic [1:0] ams,
	output logic keyon,
	output logic [3:0] mod_mask,
	output logic carrier
);
	import fm_pkg::*;

	logic upd_pending;
	logic applied;
	reg_group_e upd_group;
	logic [4:0] upd_slot;
	reg_byte_u upd_data;
	op_params_t out_op;
	ch_params_t out_ch;

	fm_slot_if slot_bus ();

	fm_write_decoder write_decoder_i (
		.clk(clk), .rst(rst), .wr(wr), .addr(addr), .din(din),
		.applied(applied), .busy(busy), .upd_pending(upd_pending),
		.upd_group(upd_group), .upd_slot(upd_slot), .upd_data(upd_data)
	);

	fm_slot_regs #(.NUM_SLOTS(NUM_SLOTS), .NUM_CH(NUM_CH)) slot_regs_i (
		.clk(clk), .rst(rst), .upd_pending(upd_pending), .upd_group(upd_group),
		.upd_slot(upd_slot), .upd_data(upd_data), .applied(applied),
		.stream(slot_bus)
	);

	fm_keyon #(.NUM_SLOTS(NUM_SLOTS)) keyon_i (
		.clk(clk), .rst(rst), .upd_pending(upd_pending), .upd_group(upd_group),
		.upd_data(upd_data), .slot_in(slot_bus), .keyon(keyon),
		.out_slot(out_slot), .out_zero(out_zero), .out_op(out_op), .out_ch(out_ch)
	);

	fm_algorithm_router algorithm_router_i (
		.clk(clk), .slot_in(slot_bus), .mod_mask(mod_mask), .carrier(carrier)
	);

	// Flatten the records onto the output pins
	assign {dt1, mul, tl, ks, ar, amsen, d1r, dt2, d2r, d1l, rr} = out_op;
	assign {rl, fb, con, kc, kf, pms, ams} = out_ch;

endmodule

`default_nettype wire

/* hw/fm_slot_if.sv */
/*
 * Slot stream
 * One slot per clock: index, first-slot flag and the operator and
 * channel parameters of that slot
 */
`timescale 1ns/100ps
`default_nettype none

interface fm_slot_if;
	import fm_pkg::*;

	logic [4:0] slot; // op*8 + channel
	logic zero; // High on slot 0
	op_params_t op;
	ch_params_t ch;

	// Slot memories drive the stream
	modport src (
		output slot,
		output zero,
		output op,
		output ch
	);

	// Key-on and routing stages read it
	modport dst (
		input slot,
		input zero,
		input op,
		input ch
	);

endinterface

`default_nettype wire

/* hw/fm_slot_regs.sv */
/*
 * Slot counter and parameter memories
 * Visits one slot per clock, presents its operator and channel
 * parameters on the slot stream and writes back the visited entries,
 * merging a pending host update when it targets the visited slot
 */
`timescale 1ns/100ps
`default_nettype none

module fm_slot_regs #(
	parameter int NUM_SLOTS = fm_pkg::NUM_SLOTS,
	parameter int NUM_CH = fm_pkg::NUM_CH
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic upd_pending,
	input wire fm_pkg::reg_group_e upd_group,
	input wire logic [4:0] upd_slot,
	input wire fm_pkg::reg_byte_u upd_data,
	output logic applied,
	fm_slot_if.src stream
);
	import fm_pkg::*;

	logic [4:0] cnt;
	logic [4:0] slot_next;
	logic zero_q;
	logic ch_wide;
	logic hit;

	op_params_t op_mem [NUM_SLOTS];
	ch_params_t ch_mem [NUM_CH];
	op_params_t op_q; // Entry for the current slot
	ch_params_t ch_q;
	op_params_t op_wr;
	ch_params_t ch_wr;

	// Read address runs one ahead so the data lines up with cnt
	assign slot_next = rst ? 5'd0 : cnt + 5'd1;

	always_ff @(posedge clk) begin
		cnt <= slot_next;
		zero_q <= slot_next == 5'd0;
	end

	// Channel groups and key-on match any operator of the channel
	assign ch_wide = upd_group inside {GRP_KEYON, GRP_RL_FB_CON, GRP_KC, GRP_KF, GRP_PMS_AMS};
	assign hit = ch_wide ? (cnt[2:0] == upd_slot[2:0]) : (cnt == upd_slot);
	assign applied = upd_pending && hit;

	always_comb begin
		op_wr = op_q;
		ch_wr = ch_q;
		if (applied) begin
			case (upd_group)
				GRP_DT1_MUL: begin
					op_wr.dt1 = upd_data.dt1_mul.dt1;
					op_wr.mul = upd_data.dt1_mul.mul;
				end
				GRP_TL: op_wr.tl = upd_data.raw[6:0];
				GRP_KS_AR: begin
					op_wr.ks = upd_data.ks_ar.ks;
					op_wr.ar = upd_data.ks_ar.ar;
				end
				GRP_AMSEN_D1R: begin
					op_wr.amsen = upd_data.amsen_d1r.amsen;
					op_wr.d1r = upd_data.amsen_d1r.d1r;
				end
				GRP_DT2_D2R: begin
					op_wr.dt2 = upd_data.dt2_d2r.dt2;
					op_wr.d2r = upd_data.dt2_d2r.d2r;
				end
				GRP_D1L_RR: begin
					op_wr.d1l = upd_data.d1l_rr.d1l;
					op_wr.rr = upd_data.d1l_rr.rr;
				end
				GRP_RL_FB_CON: begin
					ch_wr.rl = upd_data.rl_fb_con.rl;
					ch_wr.fb = upd_data.rl_fb_con.fb;
					ch_wr.con = upd_data.rl_fb_con.con;
				end
				GRP_KC: ch_wr.kc = upd_data.raw[6:0];
				GRP_KF: ch_wr.kf = upd_data.raw[7:2];
				GRP_PMS_AMS: begin
					ch_wr.pms = upd_data.pms_ams.pms;
					ch_wr.ams = upd_data.pms_ams.ams;
				end
				default: ; // Key-on lives in its own store
			endcase
		end
	end

	// Write back visited entry, read the next one
	always_ff @(posedge clk) begin
		op_mem[cnt] <= op_wr;
		ch_mem[cnt[2:0]] <= ch_wr;
		op_q <= op_mem[slot_next];
		ch_q <= ch_mem[slot_next[2:0]];
	end

	assign stream.slot = cnt;
	assign stream.zero = zero_q;
	assign stream.op = op_q;
	assign stream.ch = ch_q;

	a_zero_on_slot0: assert property (
		@(posedge clk) disable iff (rst) stream.zero == (stream.slot == 5'd0)
	);

endmodule

`default_nettype wire

/* hw/fm_write_decoder.sv */
/*
 * Host write decoder
 * Maps a host address to a register group and target slot, holds one
 * pending update and keeps busy high until the slot memories apply it
 */
`timescale 1ns/100ps
`default_nettype none

module fm_write_decoder (
	input wire logic clk,
	input wire logic rst,
	input wire logic wr,
	input wire logic [7:0] addr,
	input wire logic [7:0] din,
	input wire logic applied,
	output logic busy,
	output logic upd_pending,
	output fm_pkg::reg_group_e upd_group,
	output logic [4:0] upd_slot,
	output fm_pkg::reg_byte_u upd_data
);
	import fm_pkg::*;

	reg_group_e dec_group;
	logic [4:0] dec_slot;
	reg_byte_u din_u;

	assign din_u.raw = din;

	always_comb begin
		dec_group = GRP_NONE;
		dec_slot = addr[4:0]; // Operator groups
		if (addr == ADDR_KEYON) begin
			dec_group = GRP_KEYON;
			dec_slot = {2'b00, din_u.keyon.ch}; // Channel comes from the data
		end else if (addr[7:3] == ADDR_RL_FB_CON[7:3]) begin
			dec_group = GRP_RL_FB_CON;
		end else if (addr[7:3] == ADDR_KC[7:3]) begin
			dec_group = GRP_KC;
		end else if (addr[7:3] == ADDR_KF[7:3]) begin
			dec_group = GRP_KF;
		end else if (addr[7:3] == ADDR_PMS_AMS[7:3]) begin
			dec_group = GRP_PMS_AMS;
		end else if (addr[7:5] == ADDR_DT1_MUL[7:5]) begin
			dec_group = GRP_DT1_MUL;
		end else if (addr[7:5] == ADDR_TL[7:5]) begin
			dec_group = GRP_TL;
		end else if (addr[7:5] == ADDR_KS_AR[7:5]) begin
			dec_group = GRP_KS_AR;
		end else if (addr[7:5] == ADDR_AMSEN_D1R[7:5]) begin
			dec_group = GRP_AMSEN_D1R;
		end else if (addr[7:5] == ADDR_DT2_D2R[7:5]) begin
			dec_group = GRP_DT2_D2R;
		end else if (addr[7:5] == ADDR_D1L_RR[7:5]) begin
			dec_group = GRP_D1L_RR;
		end
	end

	// Writes while busy and unmapped addresses are dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			upd_pending <= 1'b0;
		end else if (!upd_pending && wr && dec_group != GRP_NONE) begin
			upd_pending <= 1'b1;
		end else if (applied) begin
			upd_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!upd_pending && wr) begin
			upd_group <= dec_group;
			upd_slot <= dec_slot;
			upd_data.raw <= din;
		end
	end

	assign busy = upd_pending;

	// The memories only apply something that is still pending
	a_applied_needs_pending: assert property (
		@(posedge clk) disable iff (rst) applied |-> upd_pending
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the FM register file testbench with Verilator, run it, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module fm_regs_tb -f all.f -Mdir obj_dir -o fm_regs_sim \
	&& ./obj_dir/fm_regs_sim | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

/* verif/fm_regs_tb.sv */
/*
 * Testbench for the FM register file and slot sequencer
 * Random host writes from a fixed seed, a register model kept as raw
 * register bytes, and per-cycle checks of every slot output
 */
`timescale 1ns/100ps
`default_nettype none

module fm_regs_tb;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_SLOTS = 32;
	// Host writes of all tests size the watchdog
	localparam int N_WRITES = (6 * 32 + 32) + (32 + 16) + (8 + 16) + 8 + 6;
	localparam int WATCHDOG_CYCLES = N_WRITES * 40 + 1000;

	logic clk;
	logic rst;
	logic wr;
	logic [7:0] addr;
	logic [7:0] din;
	logic [4:0] out_slot;
	logic [4:0] ar;
	logic [4:0] d1r;
	logic [4:0] d2r;
	logic [3:0] mul;
	logic [3:0] d1l;
	logic [3:0] rr;
	logic [3:0] mod_mask;
	logic [2:0] dt1;
	logic [2:0] fb;
	logic [2:0] con;
	logic [2:0] pms;
	logic [1:0] ks;
	logic [1:0] dt2;
	logic [1:0] rl;
	logic [1:0] ams;
	logic [6:0] tl;
	logic [6:0] kc;
	logic [5:0] kf;
	logic busy;
	logic out_zero;
	logic amsen;
	logic keyon;
	logic carrier;

	// Model keeps raw bytes per register group
	logic [7:0] op_reg [6][32]; // DT1_MUL, TL, KS_AR, AMSEN_D1R, DT2_D2R, D1L_RR
	logic [7:0] ch_reg [4][8]; // RL_FB_CON, KC, KF, PMS_AMS
	logic [31:0] kon_model;

	int seed;
	int errors;
	int checks;
	int tests_failed;
	logic zero_en;
	logic check_en;
	logic op_valid;
	logic ch_valid;
	logic [4:0] next_slot; // Slot expected at the next falling edge

	fm_regs_top fm_regs_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [7:0] rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Inputs change 10 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic wait_idle();
		while (busy) next_cycle();
	endtask

	task automatic model_write(input logic [7:0] a, input logic [7:0] d);
		logic [3:0] mask;
		mask = d[6:3];
		if (a == 8'h08) begin
			for (int op = 0; op < 4; op++) begin
				kon_model[{op[1:0], d[2:0]}] = mask[op[1:0]]; // Bit 0 is M1
			end
		end else if (a[7:5] == 3'b001) begin
			ch_reg[a[4:3]][a[2:0]] = d;
		end else if (a[7:6] != 2'b00) begin
			op_reg[a[7:5] - 3'd2][a[4:0]] = d;
		end
	endtask

	task automatic host_write(input logic [7:0] a, input logic [7:0] d);
		wait_idle();
		wr = 1'b1;
		addr = a;
		din = d;
		next_cycle();
		wr = 1'b0;
		model_write(a, d);
		wait_idle();
	endtask

	// Each row holds carriers, C2 mods, C1 mods and M2 mods from the top nibble down
	// Bit 0 of every nibble is M1
	function automatic logic [15:0] route_row(input logic [2:0] alg);
		case (alg)
			3'd0: return 16'b1000_0010_0001_0100;
			3'd1: return 16'b1000_0010_0000_0101;
			3'd2: return 16'b1000_0011_0000_0100;
			3'd3: return 16'b1000_0110_0001_0000;
			3'd4: return 16'b1100_0010_0001_0000;
			3'd5: return 16'b1110_0001_0001_0001;
			3'd6: return 16'b1110_0000_0001_0000;
			default: return 16'b1111_0000_0000_0000;
		endcase
	endfunction

	task automatic check_eq(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t ns, slot %0d: %s is %0h, expected %0h",
				$time, out_slot, what, got, exp);
		end
	endtask

	task automatic check_outputs();
		logic [4:0] s;
		logic [2:0] c;
		logic [15:0] row;
		logic [3:0] exp_mask;
		s = out_slot;
		c = s[2:0];
		check_eq("keyon", 8'(keyon), 8'(kon_model[s]));
		if (op_valid) begin
			check_eq("dt1", 8'(dt1), 8'(op_reg[0][s][6:4]));
			check_eq("mul", 8'(mul), 8'(op_reg[0][s][3:0]));
			check_eq("tl", 8'(tl), 8'(op_reg[1][s][6:0]));
			check_eq("ks", 8'(ks), 8'(op_reg[2][s][7:6]));
			check_eq("ar", 8'(ar), 8'(op_reg[2][s][4:0]));
			check_eq("amsen", 8'(amsen), 8'(op_reg[3][s][7]));
			check_eq("d1r", 8'(d1r), 8'(op_reg[3][s][4:0]));
			check_eq("dt2", 8'(dt2), 8'(op_reg[4][s][7:6]));
			check_eq("d2r", 8'(d2r), 8'(op_reg[4][s][4:0]));
			check_eq("d1l", 8'(d1l), 8'(op_reg[5][s][7:4]));
			check_eq("rr", 8'(rr), 8'(op_reg[5][s][3:0]));
		end
		if (ch_valid) begin
			check_eq("rl", 8'(rl), 8'(ch_reg[0][c][7:6]));
			check_eq("fb", 8'(fb), 8'(ch_reg[0][c][5:3]));
			check_eq("con", 8'(con), 8'(ch_reg[0][c][2:0]));
			check_eq("kc", 8'(kc), 8'(ch_reg[1][c][6:0]));
			check_eq("kf", 8'(kf), 8'(ch_reg[2][c][7:2]));
			check_eq("pms", 8'(pms), 8'(ch_reg[3][c][6:4]));
			check_eq("ams", 8'(ams), 8'(ch_reg[3][c][1:0]));
			row = route_row(ch_reg[0][c][2:0]);
			case (s[4:3])
				2'd1: exp_mask = row[3:0];
				2'd2: exp_mask = row[7:4];
				2'd3: exp_mask = row[11:8];
				default: exp_mask = 4'b0000; // M1 has no modulator
			endcase
			check_eq("mod_mask", 8'(mod_mask), 8'(exp_mask));
			check_eq("carrier", 8'(carrier), 8'(row[{2'b11, s[4:3]}]));
		end
	endtask

	// Sample at the falling edge where outputs are stable
	always @(negedge clk) begin
		if (zero_en) check_eq("out_zero", 8'(out_zero), 8'(out_slot == 5'd0));
		if (check_en) begin
			check_eq("out_slot", 8'(out_slot), 8'(next_slot)); // One slot per clock
			check_outputs();
		end
		next_slot = out_slot + 5'd1;
	end

	// Let every slot be revisited after the last update and then check one round
	task automatic settle_and_check();
		wait_idle();
		repeat (NUM_SLOTS + 2) next_cycle();
		check_en = 1'b1;
		repeat (NUM_SLOTS) next_cycle();
		check_en = 1'b0;
	endtask

	// Second write arrives while busy and must be dropped
	task automatic collide_writes(input logic [7:0] a1, input logic [7:0] d1,
		input logic [7:0] a2, input logic [7:0] d2);
		wait_idle();
		wr = 1'b1;
		addr = a1;
		din = d1;
		next_cycle();
		assert (busy) else begin
			errors++;
			$display("write to %0h at %0t ns did not raise busy", a1, $time);
		end
		addr = a2;
		din = d2;
		next_cycle();
		wr = 1'b0;
		model_write(a1, d1);
		wait_idle();
	endtask

	task automatic unmapped_write(input logic [7:0] a, input logic [7:0] d);
		wait_idle();
		wr = 1'b1;
		addr = a;
		din = d;
		next_cycle();
		wr = 1'b0;
		repeat (2) begin
			assert (!busy) else begin
				errors++;
				$display("write to unmapped address %0h raised busy at %0t ns", a, $time);
			end
			next_cycle();
		end
	endtask

	task automatic finish_test(input int num, input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", num, name, errors - err_before);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		logic [7:0] r;
		logic [7:0] a;
		logic [2:0] off;
		logic [2:0] ch;
		int err_before;
		seed = 32'hbba5_1907;
		errors = 0;
		checks = 0;
		tests_failed = 0;
		zero_en = 1'b0;
		check_en = 1'b0;
		op_valid = 1'b0;
		ch_valid = 1'b0;
		kon_model = '0;
		rst = 1'b1;
		wr = 1'b0;
		addr = 8'h00;
		din = 8'h00;
		repeat (3) @(posedge clk);
		#10;
		rst = 1'b0;
		zero_en = 1'b1;

		err_before = errors;
		assert (!busy) else begin
			errors++;
			$display("busy is high right after reset");
		end
		settle_and_check();
		finish_test(1, "reset state", err_before);

		err_before = errors;
		for (int g = 0; g < 6; g++) begin
			for (int s = 0; s < 32; s++) host_write(8'h40 + 8'(g * 32 + s), rand_byte());
		end
		repeat (32) begin
			a = rand_byte();
			if (a < 8'h40) a = a | 8'h40;
			host_write(a, rand_byte());
		end
		op_valid = 1'b1;
		settle_and_check();
		finish_test(2, "operator fields", err_before);

		err_before = errors;
		for (int g = 0; g < 4; g++) begin
			for (int c = 0; c < 8; c++) host_write(8'h20 + 8'(g * 8 + c), rand_byte());
		end
		repeat (16) begin
			r = rand_byte();
			host_write(8'h20 | {3'b000, r[4:0]}, rand_byte());
		end
		ch_valid = 1'b1;
		settle_and_check();
		finish_test(3, "channel fields", err_before);

		err_before = errors;
		for (int c = 0; c < 8; c++) begin
			r = rand_byte();
			host_write(8'h08, {r[7:3], 3'(c)});
		end
		repeat (16) host_write(8'h08, rand_byte());
		settle_and_check();
		finish_test(4, "key-on", err_before);

		err_before = errors;
		r = rand_byte();
		off = r[2:0];
		for (int alg = 0; alg < 8; alg++) begin
			ch = off + alg[2:0]; // Each algorithm on its own channel
			r = rand_byte();
			host_write(8'h20 | {5'b00000, ch}, {r[7:3], alg[2:0]});
		end
		settle_and_check();
		finish_test(5, "algorithm routing", err_before);

		err_before = errors;
		r = rand_byte();
		a = 8'h60 | {3'b000, r[4:0]};
		r = rand_byte();
		collide_writes(a, r, a, ~r);
		r = rand_byte();
		collide_writes(8'h08, r, 8'h08, {r[7], ~r[6:3], r[2:0]});
		repeat (2) begin
			r = rand_byte();
			a = {3'b000, r[4:0]};
			if (a == 8'h08) a = 8'h09;
			unmapped_write(a, rand_byte());
		end
		settle_and_check();
		finish_test(6, "dropped writes", err_before);

		$display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
